/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_sd_dat
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hw/sd_dat_pkg.sv
hw/dat_rd_if.sv
hw/dat_read.sv
hw/dat_buffer.sv
hw/dat_ctrl.sv
hw/sd_dat_top.sv
test/tb_sd_dat.sv

/* hw/dat_buffer.sv */
`timescale 1ns/1ps

module dat_buffer (
  input  logic        clk_i,
  input  logic        rst_i,
  dat_rd_if.fifo      wr,
  input  logic        buf_rd_i,
  output logic [31:0] buf_data_o,
  output logic        buf_valid_o,
  output logic        empty_o,
  output logic        space_ok_o
);

  typedef logic [$clog2(sd_dat_pkg::BUF_WORDS)-1:0]   ptr_t;
  typedef logic [$clog2(sd_dat_pkg::BUF_WORDS+1)-1:0] cnt_t;

  logic [31:0] mem_q [sd_dat_pkg::BUF_WORDS];
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  cnt_t        count_q;
  logic        full;
  logic        push;
  logic        pop;

  assign full = (count_q == cnt_t'(sd_dat_pkg::BUF_WORDS));
  assign pop  = buf_rd_i && !empty_o;  // Pops on an empty FIFO are dropped.
  assign push = wr.word_valid && (!full || pop);

  // ==============================
  // Storage
  // ==============================
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr.word_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two.
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // ==============================
  // Host port and levels
  // ==============================
  assign empty_o     = (count_q == '0);
  assign buf_valid_o = !empty_o;
  assign buf_data_o  = mem_q[rd_ptr_q];  // Head word falls through.

  // Room for a whole block.
  assign space_ok_o = (count_q <= cnt_t'(sd_dat_pkg::BUF_WORDS - sd_dat_pkg::BLK_WORDS));

endmodule

/* hw/dat_ctrl.sv */
`timescale 1ns/1ps

module dat_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         sd_clk_en_i,
  input  logic                         start_i,
  input  logic [15:0]                  block_count_i,
  input  logic [sd_dat_pkg::TMO_W-1:0] timeout_i,
  input  logic                         got_start_i,
  input  logic                         space_ok_i,
  input  logic                         empty_i,
  dat_rd_if.ctl                        ev,
  output logic                         rd_start_o,
  output logic                         rd_abort_o,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         pause_sd_clk_o,
  output logic                         crc_err_o,
  output logic                         end_bit_err_o,
  output logic                         timeout_err_o,
  output logic [15:0]                  blocks_left_o
);

  sd_dat_pkg::dat_state_e       state_q, state_d;
  logic [15:0]                  blocks_q;
  logic [sd_dat_pkg::TMO_W-1:0] tmo_cnt_q;
  logic                         crc_err_q;
  logic                         end_err_q;
  logic                         tmo_hit;

  // Only waits for the start bit are timed.
  assign tmo_hit = !got_start_i && (tmo_cnt_q == timeout_i);

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      sd_dat_pkg::IDLE: begin
        if (start_i) begin
          if (block_count_i == 16'd0) state_d = sd_dat_pkg::DONE;
          else if (space_ok_i)        state_d = sd_dat_pkg::START;
          else                        state_d = sd_dat_pkg::WAIT_BUF;
        end
      end
      sd_dat_pkg::WAIT_BUF: if (space_ok_i) state_d = sd_dat_pkg::START;
      sd_dat_pkg::START:    state_d = sd_dat_pkg::READING;
      sd_dat_pkg::READING: begin
        if (ev.block_done) state_d = sd_dat_pkg::BLOCK_DONE;
        else if (tmo_hit)  state_d = sd_dat_pkg::TIMEOUT;
      end
      sd_dat_pkg::BLOCK_DONE: begin
        if (blocks_q == 16'd1) state_d = sd_dat_pkg::DRAIN;  // Last block.
        else if (space_ok_i)   state_d = sd_dat_pkg::START;
        else                   state_d = sd_dat_pkg::WAIT_BUF;
      end
      sd_dat_pkg::TIMEOUT: state_d = sd_dat_pkg::DONE;
      sd_dat_pkg::DRAIN:   if (empty_i) state_d = sd_dat_pkg::DONE;
      sd_dat_pkg::DONE:    state_d = sd_dat_pkg::IDLE;
      default:             state_d = sd_dat_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= sd_dat_pkg::IDLE;
      blocks_q  <= '0;
      tmo_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == sd_dat_pkg::IDLE && start_i) begin
        blocks_q <= block_count_i;
      end else if (state_q == sd_dat_pkg::BLOCK_DONE) begin
        blocks_q <= blocks_q - 16'd1;
      end
      if (state_q == sd_dat_pkg::START) begin
        tmo_cnt_q <= '0;
      end else if (state_q == sd_dat_pkg::READING && sd_clk_en_i && !got_start_i) begin
        tmo_cnt_q <= tmo_cnt_q + 1'b1;  // Counts SD clock strobes.
      end
    end
  end

  // Reader flags are only valid with block_done.
  always_ff @(posedge clk_i) begin
    if (ev.block_done) begin
      crc_err_q <= ev.crc_err;
      end_err_q <= ev.end_bit_err;
    end
  end

  // ==============================
  // Outputs
  // ==============================
  assign rd_start_o     = (state_q == sd_dat_pkg::START);
  assign rd_abort_o     = (state_q == sd_dat_pkg::TIMEOUT);
  assign timeout_err_o  = (state_q == sd_dat_pkg::TIMEOUT);
  assign busy_o         = (state_q != sd_dat_pkg::IDLE);
  assign done_o         = (state_q == sd_dat_pkg::DONE);
  assign pause_sd_clk_o = (state_q == sd_dat_pkg::WAIT_BUF);  // No room for a block.
  assign crc_err_o      = (state_q == sd_dat_pkg::BLOCK_DONE) && crc_err_q;
  assign end_bit_err_o  = (state_q == sd_dat_pkg::BLOCK_DONE) && end_err_q;
  assign blocks_left_o  = blocks_q;

endmodule

/* hw/dat_rd_if.sv */
`timescale 1ns/1ps

interface dat_rd_if;

  logic        word_valid;   // One strobe per packed word.
  logic [31:0] word_data;
  logic        block_done;   // One pulse per block.
  logic        crc_err;      // Only valid with block_done.
  logic        end_bit_err;  // Only valid with block_done.

  modport rd (
    output word_valid,
    output word_data,
    output block_done,
    output crc_err,
    output end_bit_err
  );

  modport fifo (
    input word_valid,
    input word_data
  );

  modport ctl (
    input block_done,
    input crc_err,
    input end_bit_err
  );

endinterface

/* hw/dat_read.sv */
`timescale 1ns/1ps

module dat_read (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       sd_clk_en_i,
  input  logic [3:0] dat_i,
  input  logic       start_i,
  input  logic       abort_i,
  output logic       got_start_o,
  dat_rd_if.rd       rd
);

  typedef enum logic [2:0] {
    R_IDLE,
    R_ARMED,
    R_DATA,
    R_CRC,
    R_END
  } rd_state_e;

  // Counts data nibbles, then reused for the CRC bits.
  typedef logic [$clog2(sd_dat_pkg::BLK_WORDS * 8)-1:0] cnt_t;

  rd_state_e        state_q;
  cnt_t             cnt_q;
  logic [31:0]      word_q;
  logic [3:0][15:0] crc_q;     // Running CRC per line.
  logic [3:0][15:0] rx_crc_q;  // CRC as sent by the card.

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic bit_in);
    logic fb;
    fb = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (fb ? sd_dat_pkg::CRC_POLY : 16'h0000);
  endfunction

  // ==============================
  // Block sequencing
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= R_IDLE;
    end else if (abort_i) begin
      state_q <= R_IDLE;
    end else if (start_i) begin
      state_q <= R_ARMED;
    end else if (sd_clk_en_i) begin
      unique case (state_q)
        R_ARMED: if (dat_i == 4'h0) state_q <= R_DATA;  // Start bit on all lines.
        R_DATA: begin
          if (cnt_q == cnt_t'(sd_dat_pkg::BLK_WORDS * 8 - 1)) begin
            state_q <= R_CRC;
          end
        end
        R_CRC:   if (cnt_q == cnt_t'(15)) state_q <= R_END;
        R_END:   state_q <= R_IDLE;
        default: ;
      endcase
    end
  end

  // ==============================
  // Data path
  // ==============================
  always_ff @(posedge clk_i) begin
    if (sd_clk_en_i) begin
      unique case (state_q)
        R_ARMED: begin
          cnt_q <= '0;
          crc_q <= '0;
        end
        R_DATA: begin
          // High nibble of each byte comes first; first byte lands in 7:0.
          word_q[{cnt_q[2:1], ~cnt_q[0], 2'b00} +: 4] <= dat_i;
          for (int l = 0; l < 4; l++) begin
            crc_q[l] <= crc16_step(crc_q[l], dat_i[l]);
          end
          cnt_q <= cnt_q + 1'b1;  // Wraps to zero for the CRC phase.
        end
        R_CRC: begin
          for (int l = 0; l < 4; l++) begin
            rx_crc_q[l] <= {rx_crc_q[l][14:0], dat_i[l]};
          end
          cnt_q <= cnt_q + 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign got_start_o = (state_q == R_DATA) || (state_q == R_CRC) || (state_q == R_END);

  // Eighth nibble is merged straight from the bus.
  assign rd.word_valid = sd_clk_en_i && (state_q == R_DATA) && (cnt_q[2:0] == 3'd7);
  assign rd.word_data  = {word_q[31:28], dat_i, word_q[23:0]};

  // End bit strobe closes the block.
  assign rd.block_done  = sd_clk_en_i && (state_q == R_END);
  assign rd.crc_err     = (rx_crc_q != crc_q);
  assign rd.end_bit_err = (dat_i != 4'hF);  // All four lines must be high.

endmodule

/* hw/sd_dat_pkg.sv */
package sd_dat_pkg;

  // ==============================
  // Block and buffer geometry
  // ==============================
  localparam int BLK_WORDS = 4;  // 16 byte block.
  localparam int BUF_WORDS = 8;  // Two blocks.

  // CRC16 CCITT, seeded with zero on every line.
  localparam logic [15:0] CRC_POLY = 16'h1021;

  // Data timeout counter width.
  localparam int TMO_W = 16;

  // Read transfer controller states.
  typedef enum logic [2:0] {
    IDLE,
    WAIT_BUF,
    START,
    READING,
    BLOCK_DONE,
    TIMEOUT,
    DRAIN,
    DONE
  } dat_state_e;

endpackage

/* hw/sd_dat_top.sv */
`timescale 1ns/1ps

module sd_dat_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         sd_clk_en_i,
  input  logic [3:0]                   dat_i,
  input  logic                         start_i,
  input  logic [15:0]                  block_count_i,
  input  logic [sd_dat_pkg::TMO_W-1:0] timeout_i,
  input  logic                         buf_rd_i,
  output logic [31:0]                  buf_data_o,
  output logic                         buf_valid_o,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         pause_sd_clk_o,
  output logic                         crc_err_o,
  output logic                         end_bit_err_o,
  output logic                         timeout_err_o,
  output logic [15:0]                  blocks_left_o
);

  logic rd_start;
  logic rd_abort;
  logic got_start;
  logic space_ok;
  logic buf_empty;

  dat_rd_if rd_bus ();

  // Reader to buffer and controller.
  dat_read u_read (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sd_clk_en_i (sd_clk_en_i),
    .dat_i       (dat_i),
    .start_i     (rd_start),
    .abort_i     (rd_abort),
    .got_start_o (got_start),
    .rd          (rd_bus)
  );

  dat_buffer u_buf (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr          (rd_bus),
    .buf_rd_i    (buf_rd_i),
    .buf_data_o  (buf_data_o),
    .buf_valid_o (buf_valid_o),
    .empty_o     (buf_empty),
    .space_ok_o  (space_ok)
  );

  dat_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .sd_clk_en_i    (sd_clk_en_i),
    .start_i        (start_i),
    .block_count_i  (block_count_i),
    .timeout_i      (timeout_i),
    .got_start_i    (got_start),
    .space_ok_i     (space_ok),
    .empty_i        (buf_empty),
    .ev             (rd_bus),
    .rd_start_o     (rd_start),
    .rd_abort_o     (rd_abort),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .pause_sd_clk_o (pause_sd_clk_o),
    .crc_err_o      (crc_err_o),
    .end_bit_err_o  (end_bit_err_o),
    .timeout_err_o  (timeout_err_o),
    .blocks_left_o  (blocks_left_o)
  );

endmodule

/* test/tb_sd_dat.sv */
`timescale 1ns/1ps

module tb_sd_dat;

  localparam int TMO_CYC = 4000;
  localparam int NIBS    = sd_dat_pkg::BLK_WORDS * 8;
  localparam int W_DONE  = 0;
  localparam int W_TMO   = 1;
  localparam int W_PAUSE = 2;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic                         sd_clk_en_i = 1'b0;
  logic [3:0]                   dat_i;
  logic                         start_i;
  logic [15:0]                  block_count_i;
  logic [sd_dat_pkg::TMO_W-1:0] timeout_i;
  logic                         buf_rd_i = 1'b0;
  logic [31:0]                  buf_data_o;
  logic                         buf_valid_o;
  logic                         busy_o;
  logic                         done_o;
  logic                         pause_sd_clk_o;
  logic                         crc_err_o;
  logic                         end_bit_err_o;
  logic                         timeout_err_o;
  logic [15:0]                  blocks_left_o;

  integer      data_seed = 32'h7af81407;
  integer      pop_seed = 32'h7af81407;
  logic [31:0] pop_rnd;
  logic [31:0] exp_q [$];  // Words the card has sent in order.
  logic        host_en;
  logic [1:0]  div_q = 2'd0;
  int          n_done = 0;
  int          n_crc = 0;
  int          n_end = 0;
  int          n_tmo = 0;
  int          n_valid = 0;
  int          n_pop = 0;
  int          pause_run = 0;

  sd_dat_top uut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .sd_clk_en_i    (sd_clk_en_i),
    .dat_i          (dat_i),
    .start_i        (start_i),
    .block_count_i  (block_count_i),
    .timeout_i      (timeout_i),
    .buf_rd_i       (buf_rd_i),
    .buf_data_o     (buf_data_o),
    .buf_valid_o    (buf_valid_o),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .pause_sd_clk_o (pause_sd_clk_o),
    .crc_err_o      (crc_err_o),
    .end_bit_err_o  (end_bit_err_o),
    .timeout_err_o  (timeout_err_o),
    .blocks_left_o  (blocks_left_o)
  );

  always #10 clk_i = ~clk_i;

  // SD clock strobe one cycle in four unless paused.
  always @(posedge clk_i) begin
    div_q       <= div_q + 2'd1;
    sd_clk_en_i <= !rst_i && (div_q == 2'd3) && !pause_sd_clk_o;
  end

  // ==============================
  // Event counters
  // ==============================
  always @(posedge clk_i) begin
    if (done_o) n_done <= n_done + 1;
    if (crc_err_o) n_crc <= n_crc + 1;
    if (end_bit_err_o) n_end <= n_end + 1;
    if (timeout_err_o) n_tmo <= n_tmo + 1;
    if (buf_valid_o) n_valid <= n_valid + 1;
    pause_run <= pause_sd_clk_o ? pause_run + 1 : 0;  // Consecutive pause cycles.
  end

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // Host pops on random cycles while enabled.
  always @(posedge clk_i) begin
    if (rst_i) begin
      buf_rd_i <= 1'b0;
    end else begin
      if (buf_rd_i && buf_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("a word was popped that the card never sent");
        end else begin
          check_value("buf_data_o", exp_q.pop_front(), buf_data_o);
          n_pop <= n_pop + 1;
        end
      end
      pop_rnd = $random(pop_seed);
      buf_rd_i <= host_en && pop_rnd[0];
    end
  end

  // CRC16 of one DAT line with the first bit in the MSB.
  function automatic logic [15:0] crc16_line(input logic [NIBS-1:0] bits);
    logic [15:0] crc;
    crc = 16'h0000;
    for (int i = NIBS - 1; i >= 0; i--) begin
      crc = crc ^ {bits[i], 15'b0};
      crc = crc[15] ? ((crc << 1) ^ sd_dat_pkg::CRC_POLY) : (crc << 1);
    end
    return crc;
  endfunction

  function automatic bit cond_met(input int kind);
    case (kind)
      W_DONE:  return done_o;
      W_TMO:   return timeout_err_o;
      default: return pause_run >= 50;
    endcase
  endfunction

  task automatic wait_until(input int kind, input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TMO_CYC) abort_run({"timed out waiting for ", what});
    end while (!cond_met(kind));
  endtask

  task automatic send_nibble(input logic [3:0] nib);
    int n;
    dat_i <= nib;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TMO_CYC) abort_run("the SD clock strobe stopped for too long");
    end while (!sd_clk_en_i);
  endtask

  // ==============================
  // Card model
  // ==============================
  task automatic send_block(input bit bad_crc, input bit bad_end);
    logic [3:0]      nib [NIBS];
    logic [NIBS-1:0] line_bits [4];
    logic [15:0]     crc [4];
    logic [31:0]     word;
    logic [31:0]     rnd;
    for (int i = 0; i < NIBS; i++) begin
      rnd = $random(data_seed);
      nib[i] = rnd[3:0];
      for (int l = 0; l < 4; l++) line_bits[l][NIBS-1-i] = rnd[l];
    end
    for (int w = 0; w < sd_dat_pkg::BLK_WORDS; w++) begin
      for (int b = 0; b < 4; b++) word[8*b +: 8] = {nib[8*w+2*b], nib[8*w+2*b+1]};
      exp_q.push_back(word);
    end
    for (int l = 0; l < 4; l++) crc[l] = crc16_line(line_bits[l]);
    if (bad_crc) crc[1][5] = ~crc[1][5];
    send_nibble(4'hF);  // Idle lines.
    send_nibble(4'hF);
    send_nibble(4'h0);
    for (int i = 0; i < NIBS; i++) send_nibble(nib[i]);
    for (int i = 15; i >= 0; i--) send_nibble({crc[3][i], crc[2][i], crc[1][i], crc[0][i]});
    send_nibble(bad_end ? 4'hB : 4'hF);
    dat_i <= 4'hF;
  endtask

  task automatic run_read(input int nblk, input int crc_blk, input int end_blk, input bit stall);
    int done0, crc0, end0, tmo0, pop0;
    done0 = n_done;
    crc0 = n_crc;
    end0 = n_end;
    tmo0 = n_tmo;
    pop0 = n_pop;
    host_en <= !stall;
    block_count_i <= 16'(nblk);
    timeout_i <= 16'd1000;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(posedge clk_i);
    check_value("busy_o", 1, 32'(busy_o));
    fork
      for (int b = 0; b < nblk; b++) send_block(b == crc_blk, b == end_blk);
      if (stall) begin
        wait_until(W_PAUSE, "pause_sd_clk_o to stay high");
        // Two blocks fill the buffer, the rest wait for room.
        check_value("blocks_left_o",
                    nblk - sd_dat_pkg::BUF_WORDS / sd_dat_pkg::BLK_WORDS,
                    32'(blocks_left_o));
        host_en <= 1'b1;
      end
    join
    wait_until(W_DONE, "done_o");
    @(posedge clk_i);
    check_value("busy_o", 0, 32'(busy_o));
    check_value("pause_sd_clk_o", 0, 32'(pause_sd_clk_o));
    check_value("blocks_left_o", 0, 32'(blocks_left_o));
    check_value("done_o pulses", 1, n_done - done0);
    check_value("crc_err_o pulses", (crc_blk >= 0) ? 1 : 0, n_crc - crc0);
    check_value("end_bit_err_o pulses", (end_blk >= 0) ? 1 : 0, n_end - end0);
    check_value("timeout_err_o pulses", 0, n_tmo - tmo0);
    check_value("words popped", nblk * sd_dat_pkg::BLK_WORDS, n_pop - pop0);
    check_value("words never popped", 0, exp_q.size());
  endtask

  task automatic run_timeout();
    int done0, tmo0, valid0;
    done0 = n_done;
    tmo0 = n_tmo;
    valid0 = n_valid;
    host_en <= 1'b1;
    block_count_i <= 16'd1;
    timeout_i <= 16'd20;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    wait_until(W_TMO, "timeout_err_o");
    wait_until(W_DONE, "done_o after the timeout");
    @(posedge clk_i);
    check_value("busy_o", 0, 32'(busy_o));
    check_value("timeout_err_o pulses", 1, n_tmo - tmo0);
    check_value("done_o pulses", 1, n_done - done0);
    check_value("buf_valid_o cycles", 0, n_valid - valid0);
  endtask

  initial begin
    rst_i = 1'b1;
    dat_i = 4'hF;
    start_i = 1'b0;
    block_count_i = 16'd0;
    timeout_i = '0;
    host_en = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    check_value("busy_o", 0, 32'(busy_o));
    check_value("done_o", 0, 32'(done_o));
    check_value("pause_sd_clk_o", 0, 32'(pause_sd_clk_o));
    check_value("crc_err_o", 0, 32'(crc_err_o));
    check_value("end_bit_err_o", 0, 32'(end_bit_err_o));
    check_value("timeout_err_o", 0, 32'(timeout_err_o));
    check_value("buf_valid_o", 0, 32'(buf_valid_o));
    run_read(3, -1, -1, 1'b0);
    run_read(3, 1, -1, 1'b0);   // Bad CRC in the second block.
    run_read(2, -1, 0, 1'b0);
    run_timeout();
    run_read(4, -1, -1, 1'b1);  // Host stalls until the clock pauses.
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
